//--- hdl/devtlb_pkg.sv
// Shared request types, widths and opcode helpers for the device TLB front end, imported by every block
package devtlb_pkg;

   //========================================
   // Widths
   //========================================

   // Request address as seen by the TLB
   localparam int ADDR_WIDTH    = 64;
   // Requester transaction tag
   localparam int TAG_WIDTH     = 8;
   // Process address space id
   localparam int PASID_WIDTH   = 8;
   // Upper bound on requester ports
   localparam int MAX_PORTS     = 4;
   // Port select field, sized for MAX_PORTS
   localparam int PORT_ID_WIDTH = $clog2(MAX_PORTS);

   //========================================
   // Request encoding
   //========================================

   // Request opcodes
   typedef enum logic [1:0] {
      op_dma_rd = 2'd0,
      op_dma_wr = 2'd1,
      op_atomic = 2'd2,
      op_inval  = 2'd3
   } t_devtlb_opcode;

   // Primary request, 85 bits packed
   typedef struct packed {
      t_devtlb_opcode           opcode;
      logic [PORT_ID_WIDTH-1:0] port;
      logic                     pasid_v;
      logic [PASID_WIDTH-1:0]   pasid;
      logic [TAG_WIDTH-1:0]     tag;
      logic [ADDR_WIDTH-1:0]    address;
   } t_devtlb_req;

   // True for opcodes that move data through DMA
   function automatic logic f_opcode_is_dma(input t_devtlb_opcode opcode);
      logic is_dma;
      case (opcode)
         op_dma_rd, op_dma_wr, op_atomic: is_dma = 1'b1;
         default:                         is_dma = 1'b0;
      endcase
      return is_dma;
   endfunction

endpackage

//--- hdl/devtlb_ingress.sv
// Ingress stage of the TLB front end that registers the primary request and steers it to one slice
`timescale 1ns/1ps

module devtlb_ingress
   import devtlb_pkg::*;
#(
   parameter int NUM_PORTS = 4
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req_valid,
   input  logic                 req_prior_match,
   input  t_devtlb_req          req,
   output logic [NUM_PORTS-1:0] slice_push,
   output t_devtlb_req          slice_req
);

   // Staged strobe and payload
   logic        staged_valid;
   t_devtlb_req staged_req;

   //========================================
   // Input staging
   //========================================

   // Qualify with priority match before staging
   always_ff @(posedge clk) begin
      if (reset) begin
         staged_valid <= 1'b0;
      end else begin
         staged_valid <= req_valid && req_prior_match;
      end
   end

   // Payload captured every cycle
   always_ff @(posedge clk) begin
      staged_req <= req;
   end

   //========================================
   // Port steering
   //========================================

   // One-hot push, out of range ports dropped
   always_comb begin
      slice_push = '0;
      if (staged_valid && (int'(staged_req.port) < NUM_PORTS)) begin
         slice_push[staged_req.port] = 1'b1;
      end
   end

   // All slices see the same payload
   assign slice_req = staged_req;

endmodule

//--- hdl/devtlb_cb_slice.sv
// Per-port credit buffer that queues requests in order, masks high address bits and returns credits
`timescale 1ns/1ps

module devtlb_cb_slice
   import devtlb_pkg::*;
#(
   parameter int CB_DEPTH         = 4,
   parameter int GUEST_ADDR_WIDTH = 48
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        cb_stall,
   input  logic        push,
   input  t_devtlb_req push_req,
   input  logic        pop,
   output logic        pipe_valid,
   output t_devtlb_req pipe_req,
   output logic        credit_return
);

   localparam int PTR_WIDTH = $clog2(CB_DEPTH);
   localparam int CNT_WIDTH = $clog2(CB_DEPTH + 1);

   // Address bits kept for DMA without a PASID
   localparam logic [ADDR_WIDTH-1:0] KEEP_MASK =
      (GUEST_ADDR_WIDTH >= ADDR_WIDTH) ? '1 :
      ((ADDR_WIDTH'(1) << GUEST_ADDR_WIDTH) - ADDR_WIDTH'(1));

   // Queue storage, no reset on payload
   t_devtlb_req          entries [CB_DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] count;
   t_devtlb_req          head_req;

   //========================================
   // Queue control
   //========================================

   // Pointers wrap at CB_DEPTH, not at a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_WIDTH'(CB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_WIDTH'(CB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Occupancy
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entry write
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_req;
      end
   end

   //========================================
   // Output side
   //========================================

   assign head_req = entries[rd_ptr];

   // Defeature stall hides the head
   assign pipe_valid = (count != '0) && !cb_stall;

   // Clear upper address for DMA without PASID
   always_comb begin
      pipe_req = head_req;
      if (f_opcode_is_dma(head_req.opcode) && !head_req.pasid_v) begin
         pipe_req.address = head_req.address & KEEP_MASK;
      end
   end

   // One credit back per entry leaving
   assign credit_return = pop;

endmodule

//--- hdl/devtlb_port_arb.sv
// Round-robin arbiter that drains the credit buffer slices into one output register held until granted
`timescale 1ns/1ps

module devtlb_port_arb
   import devtlb_pkg::*;
#(
   parameter int NUM_PORTS = 4
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [NUM_PORTS-1:0] pipe_valid,
   input  t_devtlb_req          pipe_req [NUM_PORTS],
   input  logic                 out_gnt,
   output logic [NUM_PORTS-1:0] pipe_gnt,
   output logic                 out_valid,
   output t_devtlb_req          out_req
);

   // Rotating priority pointer
   logic [PORT_ID_WIDTH-1:0] rr_ptr;
   logic [PORT_ID_WIDTH-1:0] sel;
   logic                     found;
   logic                     can_load;

   //========================================
   // Selection
   //========================================

   // First valid port at or after the pointer
   always_comb begin
      int idx;
      found = 1'b0;
      sel   = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         idx = (int'(rr_ptr) + i) % NUM_PORTS;
         if (!found && pipe_valid[idx]) begin
            found = 1'b1;
            sel   = PORT_ID_WIDTH'(idx);
         end
      end
   end

   // Output register empty or draining this cycle
   assign can_load = !out_valid || out_gnt;

   // One-hot pop to the chosen slice
   always_comb begin
      pipe_gnt = '0;
      if (found && can_load) begin
         pipe_gnt[sel] = 1'b1;
      end
   end

   //========================================
   // Output register
   //========================================

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         rr_ptr    <= '0;
      end else if (found && can_load) begin
         out_valid <= 1'b1;
         // Skip past the winner
         rr_ptr    <= (int'(sel) == NUM_PORTS - 1) ? '0 : sel + 1'b1;
      end else if (out_gnt) begin
         out_valid <= 1'b0;
      end
   end

   // Payload loads only on a grant
   always_ff @(posedge clk) begin
      if (found && can_load) begin
         out_req <= pipe_req[sel];
      end
   end

endmodule

//--- hdl/devtlb_front.sv
// Top level of the device TLB request front end, joining ingress, per-port credit buffers and arbiter
`timescale 1ns/1ps

module devtlb_front
   import devtlb_pkg::*;
#(
   parameter int NUM_PORTS        = 4,
   parameter int CB_DEPTH         = 4,
   parameter int GUEST_ADDR_WIDTH = 48
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req_valid,
   input  logic                 req_prior_match,
   input  t_devtlb_req          req,
   input  logic                 cb_stall,
   input  logic                 out_gnt,
   output logic [NUM_PORTS-1:0] credit_return,
   output logic                 out_valid,
   output t_devtlb_req          out_req
);

   // Ingress to slices
   logic [NUM_PORTS-1:0] slice_push;
   t_devtlb_req          slice_req;
   // Slices to arbiter
   logic [NUM_PORTS-1:0] pipe_valid;
   t_devtlb_req          pipe_req [NUM_PORTS];
   logic [NUM_PORTS-1:0] pipe_gnt;

   devtlb_ingress #(
      .NUM_PORTS (NUM_PORTS)
   ) ingress0 (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_prior_match (req_prior_match),
      .req             (req),
      .slice_push      (slice_push),
      .slice_req       (slice_req)
   );

   //========================================
   // Credit buffer slices
   //========================================

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_slice
      devtlb_cb_slice #(
         .CB_DEPTH         (CB_DEPTH),
         .GUEST_ADDR_WIDTH (GUEST_ADDR_WIDTH)
      ) slice (
         .clk           (clk),
         .reset         (reset),
         .cb_stall      (cb_stall),
         .push          (slice_push[i]),
         .push_req      (slice_req),
         .pop           (pipe_gnt[i]),
         .pipe_valid    (pipe_valid[i]),
         .pipe_req      (pipe_req[i]),
         .credit_return (credit_return[i])
      );
   end

   // Single drain point toward the TLB
   devtlb_port_arb #(
      .NUM_PORTS (NUM_PORTS)
   ) arb0 (
      .clk        (clk),
      .reset      (reset),
      .pipe_valid (pipe_valid),
      .pipe_req   (pipe_req),
      .out_gnt    (out_gnt),
      .pipe_gnt   (pipe_gnt),
      .out_valid  (out_valid),
      .out_req    (out_req)
   );

endmodule

//--- testbench/devtlb_front_sva.sv
// Concurrent assertions bound into the TLB front end top level for credits, stall and output hold
`timescale 1ns/1ps

module devtlb_front_sva
   import devtlb_pkg::*;
#(
   parameter int NUM_PORTS = 4,
   parameter int CB_DEPTH  = 4
) (
   input logic                 clk,
   input logic                 reset,
   input logic                 cb_stall,
   input logic [NUM_PORTS-1:0] slice_push,
   input logic [NUM_PORTS-1:0] pipe_valid,
   input logic [NUM_PORTS-1:0] pipe_gnt,
   input logic [NUM_PORTS-1:0] credit_return,
   input logic                 out_valid,
   input logic                 out_gnt,
   input t_devtlb_req          out_req
);

   // Shadow occupancy per slice
   int occupancy [NUM_PORTS];

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (reset) begin
            occupancy[i] <= 0;
         end else begin
            occupancy[i] <= occupancy[i] + int'(slice_push[i]) - int'(pipe_gnt[i]);
         end
      end
   end

   // At most one credit back per cycle
   a_credit_one: assert property (@(posedge clk) disable iff (reset)
      $onehot0(credit_return))
      else $error("more than one credit returned in one cycle");

   a_out_hold: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_gnt |=> out_valid && $stable(out_req))
      else $error("output changed while waiting for grant");

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_full
      // Valid follows shadow occupancy, hidden by the stall
      a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
         pipe_valid[i] == ((occupancy[i] != 0) && !cb_stall))
         else $error("slice valid does not match its occupancy and the stall");

      a_no_overflow: assert property (@(posedge clk) disable iff (reset)
         slice_push[i] |-> occupancy[i] < CB_DEPTH)
         else $error("push into a full credit buffer");
   end

endmodule

//--- testbench/devtlb_front_tb.sv
// Random-stimulus testbench for the TLB front end; drives dut0 and checks it against a queue model
`timescale 1ns/1ps

module devtlb_front_tb
   import devtlb_pkg::*;
();

   localparam int NUM_PORTS   = 4;
   localparam int CB_DEPTH    = 4;
   localparam int NUM_REQS    = 2000;
   // Credit depth plus the output register, rounded up
   localparam int MODEL_SLOTS = 8;
   localparam logic [ADDR_WIDTH-1:0] GUEST_MASK = 64'h0000_ffff_ffff_ffff;

   logic                 clk;
   logic                 reset;
   logic                 req_valid;
   logic                 req_prior_match;
   t_devtlb_req          req;
   logic                 cb_stall;
   logic                 out_gnt;
   logic [NUM_PORTS-1:0] credit_return;
   logic                 out_valid;
   t_devtlb_req          out_req;

   // Model state, stimulus side
   t_devtlb_req exp_mem [NUM_PORTS][MODEL_SLOTS];
   int          pushed [NUM_PORTS] = '{default: 0};
   logic [15:0] lfsr_state;
   int          stall_left;
   int          sent;
   // Model state, monitor side
   int                   popped [NUM_PORTS] = '{default: 0};
   int                   returns [NUM_PORTS] = '{default: 0};
   logic [NUM_PORTS-1:0] passed_by [NUM_PORTS] = '{default: '0};
   logic                 hold_prev = 1'b0;
   t_devtlb_req          req_prev = '0;

   devtlb_front dut0 (.*);

   bind devtlb_front devtlb_front_sva #(
      .NUM_PORTS (NUM_PORTS),
      .CB_DEPTH  (CB_DEPTH)
   ) sva0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //========================================
   // Helpers
   //========================================

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // One step per bit taken
   task automatic draw_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
   endtask

   task automatic stop_failed(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "simulation stopped after a failure");
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "simulation stopped after a mismatch");
      end
   endtask

   // DMA without PASID keeps the low 48 address bits only
   function automatic t_devtlb_req expect_masked(input t_devtlb_req r);
      t_devtlb_req e;
      e = r;
      if (r.opcode != op_inval && !r.pasid_v) begin
         e.address = r.address & GUEST_MASK;
      end
      return e;
   endfunction

   function automatic int outstanding();
      int sum;
      sum = 0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         sum += pushed[i] - popped[i];
      end
      return sum;
   endfunction

   // Grant, stall phase and optionally one request
   task automatic drive_cycle(input logic allow_req);
      logic [63:0] r;
      t_devtlb_req nr;
      int          p;
      draw_bits(2, r);
      out_gnt = (r[1:0] != 2'b00);
      if (stall_left > 0) begin
         cb_stall = 1'b1;
         stall_left--;
      end else begin
         cb_stall = 1'b0;
         draw_bits(5, r);
         if (r[4:0] == 5'd0) begin
            draw_bits(3, r);
            stall_left = int'(r[2:0]) + 1;
         end
      end
      req_valid = 1'b0;
      req_prior_match = 1'b0;
      if (allow_req) begin
         draw_bits(2, r);
         nr.port = r[1:0];
         draw_bits(2, r);
         nr.opcode = t_devtlb_opcode'(r[1:0]);
         draw_bits(1, r);
         nr.pasid_v = r[0];
         draw_bits(8, r);
         nr.pasid = r[7:0];
         draw_bits(8, r);
         nr.tag = r[7:0];
         draw_bits(64, r);
         nr.address = r;
         draw_bits(3, r);
         p = int'(nr.port);
         req = nr;
         if (r[2:0] == 3'd0) begin
            // No priority match, so dropped at ingress
            req_valid = 1'b1;
         end else if (CB_DEPTH - pushed[p] + returns[p] > 0) begin
            req_valid = 1'b1;
            req_prior_match = 1'b1;
            exp_mem[p][pushed[p] % MODEL_SLOTS] = expect_masked(nr);
            pushed[p]++;
            sent++;
         end else begin
            // Qualifier alone is not a request
            req_prior_match = 1'b1;
         end
      end
   endtask

   //========================================
   // Output monitor, sampled mid-cycle
   //========================================

   always @(negedge clk) begin
      int p;
      if (!reset) begin
         // Held output must not move
         if (hold_prev) begin
            check_value("out_valid", 128'(out_valid), 128'(1'b1));
            check_value("out_req", 128'(out_req), 128'(req_prev));
         end
         if (cb_stall) begin
            check_value("credit_return", 128'(credit_return), 128'(0));
         end
         for (int i = 0; i < NUM_PORTS; i++) begin
            if (credit_return[i]) begin
               returns[i]++;
               if (returns[i] > pushed[i]) begin
                  stop_failed("credit returned on a port with nothing outstanding");
               end
            end
         end
         // Round robin, no port passes a waiting port twice
         if (dut0.pipe_gnt != '0) begin
            p = 0;
            for (int i = 0; i < NUM_PORTS; i++) begin
               if (dut0.pipe_gnt[i]) begin
                  p = i;
               end
            end
            for (int q = 0; q < NUM_PORTS; q++) begin
               if (q != p && dut0.pipe_valid[q]) begin
                  if (passed_by[q][p]) begin
                     stop_failed("arbiter served one port twice while another port waited");
                  end
                  passed_by[q][p] = 1'b1;
               end
            end
            passed_by[p] = '0;
         end
         if (out_valid && out_gnt) begin
            p = int'(out_req.port);
            if (pushed[p] == popped[p]) begin
               stop_failed("output transfer with no request expected on its port");
            end
            check_value("out_req", 128'(out_req), 128'(exp_mem[p][popped[p] % MODEL_SLOTS]));
            popped[p]++;
         end
         hold_prev = out_valid && !out_gnt;
         req_prev = out_req;
      end
   end

   //========================================
   // Main sequence
   //========================================

   initial begin
      int cycles;
      lfsr_state = 16'd83;
      stall_left = 0;
      sent = 0;
      reset = 1'b1;
      req_valid = 1'b0;
      req_prior_match = 1'b0;
      req = '0;
      cb_stall = 1'b0;
      out_gnt = 1'b0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      cycles = 0;
      while (sent < NUM_REQS) begin
         @(posedge clk);
         #1;
         drive_cycle(1'b1);
         cycles++;
         if (cycles > 20 * NUM_REQS) begin
            stop_failed("timeout while sending requests");
         end
      end
      // Drain with random grant and stall
      cycles = 0;
      while (outstanding() != 0 || out_valid) begin
         @(posedge clk);
         #1;
         drive_cycle(1'b0);
         cycles++;
         if (cycles > 1000) begin
            stop_failed("timeout while draining the queues");
         end
      end
      for (int i = 0; i < NUM_PORTS; i++) begin
         check_value("credits", 128'(CB_DEPTH - pushed[i] + returns[i]), 128'(CB_DEPTH));
         check_value("credit_returns", 128'(returns[i]), 128'(popped[i]));
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- list.f
hdl/devtlb_pkg.sv
hdl/devtlb_ingress.sv
hdl/devtlb_cb_slice.sv
hdl/devtlb_port_arb.sv
hdl/devtlb_front.sv
testbench/devtlb_front_sva.sv
testbench/devtlb_front_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TLB front end testbench with Verilator

verilator --binary --timing --assert -j 0 -f list.f --top-module devtlb_front_tb -o devtlb_front_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/devtlb_front_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0
